// ==== list.f ====
tlb_pkg.sv
tlb_storage.sv
tlb_way.sv
tlb_assoc.sv
tlb_sweep_counter.sv
tlb_flush_fsm.sv
tlb_top.sv
tlb_checker.sv
tlb_monitor.sv
tlb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the TLB testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tlb_tb -f list.f
out=$(./obj_dir/Vtlb_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "sim passed"

// ==== tlb_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_tb;

    import tlb_pkg::*;

    localparam int ENTRIES_W  = 4;
    localparam int WAYS_W     = 2;
    localparam int SETS       = 2**ENTRIES_W;
    localparam int WAYS       = 2**WAYS_W;
    localparam int VTAG_W     = VPN_W - ENTRIES_W;
    localparam int CLK_PERIOD = 4;
    localparam int RAND_CMDS  = 500;
    // bound on the directed command cycles of tests 1 to 5
    localparam int DIRECTED_CYCLES = 200;
    localparam int WATCHDOG_NS =
        (RAND_CMDS + DIRECTED_CYCLES + 20 * (SETS + 2)) * CLK_PERIOD;

    logic                 clk = 1'b0;
    logic                 rst_n;
    tlb_cmd_t             cmd;
    logic [VPN_W-1:0]     vpn;
    logic [VPN_W-1:0]     vpn_w;
    logic [ATAG_W-1:0]    atag_w;
    logic [PPN_W-1:0]     ppn_w;
    logic [ENTRIES_W-1:0] inv_index;
    logic                 flush;
    logic                 busy;
    logic                 hit;
    logic [ATAG_W-1:0]    atag_r;
    logic [PPN_W-1:0]     ppn_r;
    logic                 test_done;
    int                   test_id;
    int                   check_count;
    int                   error_count;
    int                   assert_fails;
    int                   seed;

    tlb_top #(.ENTRIES_W(ENTRIES_W), .WAYS_W(WAYS_W)) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .vpn       (vpn),
        .vpn_w     (vpn_w),
        .atag_w    (atag_w),
        .ppn_w     (ppn_w),
        .inv_index (inv_index),
        .flush     (flush),
        .busy      (busy),
        .hit       (hit),
        .atag_r    (atag_r),
        .ppn_r     (ppn_r)
    );

    tlb_monitor #(.ENTRIES_W(ENTRIES_W), .WAYS_W(WAYS_W)) i_mon (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .vpn         (vpn),
        .vpn_w       (vpn_w),
        .atag_w      (atag_w),
        .ppn_w       (ppn_w),
        .inv_index   (inv_index),
        .flush       (flush),
        .busy        (busy),
        .hit         (hit),
        .atag_r      (atag_r),
        .ppn_r       (ppn_r),
        .test_done   (test_done),
        .test_id     (test_id),
        .check_count (check_count),
        .error_count (error_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [VPN_W-1:0] rand_vpn();
        logic [31:0] r;
        r = rand_word();
        return r[VPN_W-1:0];
    endfunction

    function automatic logic [PPN_W-1:0] rand_ppn();
        logic [31:0] r;
        r = rand_word();
        return r[PPN_W-1:0];
    endfunction

    function automatic logic [ATAG_W-1:0] rand_atag();
        logic [31:0] r;
        r = rand_word();
        return r[ATAG_W-1:0];
    endfunction

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic resolve_addr(input logic [VPN_W-1:0] a);
        cmd = TLB_CMD_RESOLVE;
        vpn = a;
        step();
        cmd = TLB_CMD_NONE;
    endtask

    task automatic write_entry(input logic [VPN_W-1:0] a, input logic [ATAG_W-1:0] t,
                               input logic [PPN_W-1:0] p);
        cmd    = TLB_CMD_WRITE;
        vpn_w  = a;
        atag_w = t;
        ppn_w  = p;
        step();
        cmd = TLB_CMD_NONE;
    endtask

    task automatic invalidate_set(input logic [ENTRIES_W-1:0] idx);
        cmd       = TLB_CMD_INVALIDATE;
        inv_index = idx;
        step();
        cmd = TLB_CMD_NONE;
    endtask

    task automatic wait_idle();
        while (busy) begin
            step();
        end
    endtask

    task automatic end_test(input int id);
        test_id   = id;
        test_done = 1'b1;
        step();
        test_done = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [VPN_W-1:0] a;
        logic [VPN_W-1:0] b;
        logic [31:0]      r;
        seed      = 32'h2d996442;
        rst_n     = 1'b0;
        cmd       = TLB_CMD_NONE;
        vpn       = '0;
        vpn_w     = '0;
        atag_w    = '0;
        ppn_w     = '0;
        inv_index = '0;
        flush     = 1'b0;
        test_done = 1'b0;
        test_id   = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // 1: power-up sweep, then everything misses
        wait_idle();
        for (int i = 0; i < SETS; i++) begin
            resolve_addr(rand_vpn());
        end
        end_test(1);

        // 2: valid entries hit, entries without the valid bit miss
        for (int i = 0; i < 4; i++) begin
            a = rand_vpn();
            b = rand_vpn();
            write_entry(a, rand_atag() | 8'h01, rand_ppn());
            resolve_addr(a);
            write_entry(b, rand_atag() & 8'hfe, rand_ppn());
            resolve_addr(b);
        end
        end_test(2);

        // 3: WAYS + 1 tags in set 5, then a duplicated tag
        for (int i = 0; i <= WAYS; i++) begin
            write_entry({VTAG_W'(i + 1), ENTRIES_W'(5)}, rand_atag() | 8'h01, rand_ppn());
        end
        for (int i = 0; i <= WAYS; i++) begin
            resolve_addr({VTAG_W'(i + 1), ENTRIES_W'(5)});
        end
        a = {VTAG_W'(9), ENTRIES_W'(7)};
        write_entry(a, 8'h03, rand_ppn());
        write_entry(a, 8'h05, rand_ppn());
        resolve_addr(a);
        end_test(3);

        // 4: invalidate set 2, sets 3 and 5 keep their entries
        a = {VTAG_W'(rand_vpn() >> ENTRIES_W), ENTRIES_W'(2)};
        b = {VTAG_W'(rand_vpn() >> ENTRIES_W), ENTRIES_W'(3)};
        write_entry(a, 8'h01, rand_ppn());
        write_entry(b, 8'h01, rand_ppn());
        invalidate_set(ENTRIES_W'(2));
        resolve_addr(a);
        resolve_addr(b);
        resolve_addr({VTAG_W'(WAYS + 1), ENTRIES_W'(5)});
        end_test(4);

        // 5: flush pulse clears all earlier entries
        resolve_addr(b);
        flush = 1'b1;
        step();
        flush = 1'b0;
        wait_idle();
        resolve_addr(b);
        resolve_addr(a);
        resolve_addr({VTAG_W'(WAYS + 1), ENTRIES_W'(5)});
        end_test(5);

        // 6: random mix on a small tag pool so that entries get reused
        for (int i = 0; i < RAND_CMDS; i++) begin
            r = rand_word();
            a = rand_vpn();
            a[VPN_W-1:ENTRIES_W+2] = '0;
            case (r % 3)
                0: resolve_addr(a);
                1: write_entry(a, rand_atag(), rand_ppn());
                default: invalidate_set(a[ENTRIES_W-1:0]);
            endcase
        end
        end_test(6);

        assert_fails = i_dut.i_fsm.i_checker.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tlb_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_monitor #(
    parameter int ENTRIES_W = 4,
    parameter int WAYS_W    = 2
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire tlb_pkg::tlb_cmd_t           cmd,
    input  wire logic [tlb_pkg::VPN_W-1:0]   vpn,
    input  wire logic [tlb_pkg::VPN_W-1:0]   vpn_w,
    input  wire logic [tlb_pkg::ATAG_W-1:0]  atag_w,
    input  wire logic [tlb_pkg::PPN_W-1:0]   ppn_w,
    input  wire logic [ENTRIES_W-1:0]        inv_index,
    input  wire logic                        flush,
    input  wire logic                        busy,
    input  wire logic                        hit,
    input  wire logic [tlb_pkg::ATAG_W-1:0]  atag_r,
    input  wire logic [tlb_pkg::PPN_W-1:0]   ppn_r,
    input  wire logic                        test_done,
    input  wire logic [31:0]                 test_id,
    output      int                          check_count,
    output      int                          error_count
);

    import tlb_pkg::*;

    localparam int SETS   = 2**ENTRIES_W;
    localparam int WAYS   = 2**WAYS_W;
    localparam int VTAG_W = VPN_W - ENTRIES_W;
    localparam int RES_W  = 1 + ATAG_W + PPN_W;

    // model of the tag memories, valid is atag bit 0
    logic [ATAG_W-1:0] m_atag [WAYS][SETS];
    logic [VTAG_W-1:0] m_vtag [WAYS][SETS];
    logic [PPN_W-1:0]  m_ppn  [WAYS][SETS];
    int                m_victim;

    logic              pending = 1'b0;
    logic [RES_W-1:0]  exp_res;
    logic [VPN_W-1:0]  exp_vpn;
    // busy cycles still expected from the current sweep
    int                busy_left = 0;
    int                t_checks = 0;
    int                t_errors = 0;

    // expected {hit, atag, ppn}, highest matching way wins
    function automatic logic [RES_W-1:0] ref_resolve(input logic [VPN_W-1:0] addr);
        logic [RES_W-1:0] res;
        int               idx;
        res = '0;
        idx = int'(addr[ENTRIES_W-1:0]);
        for (int w = 0; w < WAYS; w++) begin
            if (m_atag[w][idx][0] && m_vtag[w][idx] == addr[VPN_W-1:ENTRIES_W]) begin
                res = {1'b1, m_atag[w][idx], m_ppn[w][idx]};
            end
        end
        return res;
    endfunction

    task automatic clear_model();
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                m_atag[w][s] = '0;
            end
        end
    endtask

    always @(posedge clk) begin
        // outputs of the resolve issued one cycle earlier
        if (pending) begin
            check_count++;
            t_checks++;
            if (hit !== exp_res[RES_W-1] ||
                (exp_res[RES_W-1] && {atag_r, ppn_r} !== exp_res[RES_W-2:0])) begin
                error_count++;
                t_errors++;
                $display("ERROR %0t: resolve %h exp hit %0b atag %h ppn %h, got %0b %h %h",
                         $time, exp_vpn, exp_res[RES_W-1], exp_res[RES_W-2:PPN_W],
                         exp_res[PPN_W-1:0], hit, atag_r, ppn_r);
            end
        end
        pending = 1'b0;

        if (!rst_n) begin
            // power-up sweep starts on reset release
            clear_model();
            m_victim    = 0;
            busy_left   = SETS + 1;
            check_count = 0;
            error_count = 0;
        end else begin
            check_count++;
            t_checks++;
            if (busy !== (busy_left != 0)) begin
                error_count++;
                t_errors++;
                $display("ERROR %0t: busy %0b, expected %0b", $time, busy, busy_left != 0);
            end
            if (busy_left != 0) begin
                // the sweep leaves every set invalid
                clear_model();
                busy_left--;
            end else begin
                if (flush) begin
                    busy_left = SETS + 1;
                end
                case (cmd)
                    TLB_CMD_RESOLVE: begin
                        exp_res = ref_resolve(vpn);
                        exp_vpn = vpn;
                        pending = 1'b1;
                    end
                    TLB_CMD_WRITE: begin
                        m_atag[m_victim][int'(vpn_w[ENTRIES_W-1:0])] = atag_w;
                        m_vtag[m_victim][int'(vpn_w[ENTRIES_W-1:0])] =
                            vpn_w[VPN_W-1:ENTRIES_W];
                        m_ppn[m_victim][int'(vpn_w[ENTRIES_W-1:0])]  = ppn_w;
                        m_victim = (m_victim + 1) % WAYS;
                    end
                    TLB_CMD_INVALIDATE: begin
                        for (int w = 0; w < WAYS; w++) begin
                            m_atag[w][int'(inv_index)] = '0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end

        if (test_done) begin
            $display("test %0d done: %0d checks, %0d errors, %s",
                     test_id, t_checks, t_errors, t_errors == 0 ? "ok" : "FAIL");
            t_checks = 0;
            t_errors = 0;
        end
    end

endmodule

`default_nettype wire

// ==== tlb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_checker #(
    parameter int ENTRIES_W = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   flush,
    input  wire tlb_pkg::flush_state_t  state,
    input  wire logic                   busy,
    input  wire tlb_pkg::tlb_cmd_t      way_cmd,
    input  wire logic [ENTRIES_W-1:0]   way_inv_index
);

    import tlb_pkg::*;

    localparam int SETS = 2**ENTRIES_W;

    int sweep_len;
    int busy_fails = 0;
    int cmd_fails  = 0;
    int len_fails  = 0;
    int fail_count;

    assign fail_count = busy_fails + cmd_fails + len_fails;

    // cycles spent so far in the current sweep
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_len <= 0;
        end else if (state == FLUSH_SWEEP) begin
            sweep_len <= sweep_len + 1;
        end else begin
            sweep_len <= 0;
        end
    end

    // busy rises only on a flush while idle and falls only out of FLUSH_DONE
    busy_follows_state: assert property (@(posedge clk) disable iff (!rst_n)
        busy != $past(busy) |-> (busy ? ($past(state) == FLUSH_IDLE && $past(flush))
                                      : $past(state) == FLUSH_DONE))
        else begin
            busy_fails++;
            $error("busy does not follow the flush state");
        end

    // sets are swept in order starting at 0
    sweep_invalidates: assert property (@(posedge clk) disable iff (!rst_n)
        state == FLUSH_SWEEP |-> (way_cmd == TLB_CMD_INVALIDATE
                                  && way_inv_index == ENTRIES_W'(sweep_len)))
        else begin
            cmd_fails++;
            $error("sweep does not invalidate the next set in order");
        end

    // one sweep cycle per set, then FLUSH_DONE
    sweep_length: assert property (@(posedge clk) disable iff (!rst_n)
        state == FLUSH_SWEEP |=> (sweep_len < SETS ? state == FLUSH_SWEEP
                                                  : state == FLUSH_DONE))
        else begin
            len_fails++;
            $error("sweep did not last one cycle per set");
        end

endmodule

bind tlb_flush_fsm tlb_checker #(.ENTRIES_W(ENTRIES_W)) i_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .state         (state),
    .busy          (busy),
    .way_cmd       (way_cmd),
    .way_inv_index (way_inv_index)
);

`default_nettype wire

// ==== tlb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_top #(
    parameter int ENTRIES_W = 4,
    parameter int WAYS_W    = 2
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire tlb_pkg::tlb_cmd_t           cmd,
    input  wire logic [tlb_pkg::VPN_W-1:0]   vpn,
    input  wire logic [tlb_pkg::VPN_W-1:0]   vpn_w,
    input  wire logic [tlb_pkg::ATAG_W-1:0]  atag_w,
    input  wire logic [tlb_pkg::PPN_W-1:0]   ppn_w,
    input  wire logic [ENTRIES_W-1:0]        inv_index,
    input  wire logic                        flush,
    output      logic                        busy,
    output      logic                        hit,
    output      logic [tlb_pkg::ATAG_W-1:0]  atag_r,
    output      logic [tlb_pkg::PPN_W-1:0]   ppn_r
);

    import tlb_pkg::*;

    tlb_cmd_t             way_cmd;
    logic [ENTRIES_W-1:0] way_inv_index;
    logic [ENTRIES_W-1:0] sweep_index;
    logic                 sweep_last;
    logic                 count_clear;
    logic                 count_en;

    tlb_flush_fsm #(.ENTRIES_W(ENTRIES_W)) i_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .cmd           (cmd),
        .sweep_index   (sweep_index),
        .sweep_last    (sweep_last),
        .way_cmd       (way_cmd),
        .way_inv_index (way_inv_index),
        .inv_index     (inv_index),
        .busy          (busy),
        .count_clear   (count_clear),
        .count_en      (count_en)
    );

    tlb_sweep_counter #(.ENTRIES_W(ENTRIES_W)) i_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .count_clear (count_clear),
        .count_en    (count_en),
        .sweep_index (sweep_index),
        .sweep_last  (sweep_last)
    );

    tlb_assoc #(.ENTRIES_W(ENTRIES_W), .WAYS_W(WAYS_W)) i_assoc (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (way_cmd),
        .vpn       (vpn),
        .vpn_w     (vpn_w),
        .atag_w    (atag_w),
        .ppn_w     (ppn_w),
        .inv_index (way_inv_index),
        .hit       (hit),
        .atag_r    (atag_r),
        .ppn_r     (ppn_r)
    );

endmodule

`default_nettype wire

// ==== tlb_flush_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_flush_fsm #(
    parameter int ENTRIES_W = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 flush,
    input  wire tlb_pkg::tlb_cmd_t    cmd,
    input  wire logic [ENTRIES_W-1:0] sweep_index,
    input  wire logic                 sweep_last,
    output      tlb_pkg::tlb_cmd_t    way_cmd,
    output      logic [ENTRIES_W-1:0] way_inv_index,
    input  wire logic [ENTRIES_W-1:0] inv_index,
    output      logic                 busy,
    output      logic                 count_clear,
    output      logic                 count_en
);

    import tlb_pkg::*;

    flush_state_t state;
    flush_state_t state_nxt;

    // tag memories come up unknown, so sweep right out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= FLUSH_SWEEP;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt     = state;
        way_cmd       = TLB_CMD_NONE;
        way_inv_index = sweep_index;
        count_clear   = 1'b1;
        count_en      = 1'b0;
        case (state)
            FLUSH_IDLE: begin
                way_cmd       = cmd;
                way_inv_index = inv_index;
                if (flush) begin
                    state_nxt = FLUSH_SWEEP;
                end
            end
            FLUSH_SWEEP: begin
                way_cmd     = TLB_CMD_INVALIDATE;
                count_clear = 1'b0;
                count_en    = 1'b1;
                if (sweep_last) begin
                    state_nxt = FLUSH_DONE;
                end
            end
            FLUSH_DONE: begin
                state_nxt = FLUSH_IDLE;
            end
            default: begin
                state_nxt = FLUSH_SWEEP;
            end
        endcase
    end

    assign busy = (state != FLUSH_IDLE);

endmodule

`default_nettype wire

// ==== tlb_sweep_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_sweep_counter #(
    parameter int ENTRIES_W = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 count_clear,
    input  wire logic                 count_en,
    output      logic [ENTRIES_W-1:0] sweep_index,
    output      logic                 sweep_last
);

    // clear wins over enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_index <= '0;
        end else if (count_clear) begin
            sweep_index <= '0;
        end else if (count_en) begin
            sweep_index <= sweep_index + 1'b1;
        end
    end

    // top set of the way
    assign sweep_last = (sweep_index == {ENTRIES_W{1'b1}});

endmodule

`default_nettype wire

// ==== tlb_assoc.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_assoc #(
    parameter int ENTRIES_W = 4,
    parameter int WAYS_W    = 2
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire tlb_pkg::tlb_cmd_t           cmd,
    input  wire logic [tlb_pkg::VPN_W-1:0]   vpn,
    input  wire logic [tlb_pkg::VPN_W-1:0]   vpn_w,
    input  wire logic [tlb_pkg::ATAG_W-1:0]  atag_w,
    input  wire logic [tlb_pkg::PPN_W-1:0]   ppn_w,
    input  wire logic [ENTRIES_W-1:0]        inv_index,
    output      logic                        hit,
    output      logic [tlb_pkg::ATAG_W-1:0]  atag_r,
    output      logic [tlb_pkg::PPN_W-1:0]   ppn_r
);

    import tlb_pkg::*;

    localparam int WAYS = 2**WAYS_W;

    logic [WAYS_W-1:0] victim;
    tlb_cmd_t          way_cmd  [WAYS];
    logic [WAYS-1:0]   way_hit;
    logic [ATAG_W-1:0] way_atag [WAYS];
    logic [PPN_W-1:0]  way_ppn  [WAYS];

    // round-robin replacement, advances once per write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            victim <= '0;
        end else if (cmd == TLB_CMD_WRITE) begin
            victim <= victim + 1'b1;
        end
    end

    for (genvar g = 0; g < WAYS; g++) begin : g_way
        // writes reach only the victim, everything else is broadcast
        always_comb begin
            way_cmd[g] = cmd;
            if (cmd == TLB_CMD_WRITE && victim != WAYS_W'(g)) begin
                way_cmd[g] = TLB_CMD_NONE;
            end
        end

        tlb_way #(.ENTRIES_W(ENTRIES_W)) i_way (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd       (way_cmd[g]),
            .vpn       (vpn),
            .hit       (way_hit[g]),
            .atag_r    (way_atag[g]),
            .ppn_r     (way_ppn[g]),
            .vpn_w     (vpn_w),
            .atag_w    (atag_w),
            .ppn_w     (ppn_w),
            .inv_index (inv_index)
        );
    end

    // highest hitting way wins, way 0 shown on a miss
    always_comb begin
        hit    = way_hit[0];
        atag_r = way_atag[0];
        ppn_r  = way_ppn[0];
        for (int i = 1; i < WAYS; i++) begin
            if (way_hit[i]) begin
                hit    = 1'b1;
                atag_r = way_atag[i];
                ppn_r  = way_ppn[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== tlb_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_way #(
    parameter int ENTRIES_W = 4
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire tlb_pkg::tlb_cmd_t           cmd,
    input  wire logic [tlb_pkg::VPN_W-1:0]   vpn,
    output      logic                        hit,
    output      logic [tlb_pkg::ATAG_W-1:0]  atag_r,
    output      logic [tlb_pkg::PPN_W-1:0]   ppn_r,
    input  wire logic [tlb_pkg::VPN_W-1:0]   vpn_w,
    input  wire logic [tlb_pkg::ATAG_W-1:0]  atag_w,
    input  wire logic [tlb_pkg::PPN_W-1:0]   ppn_w,
    input  wire logic [ENTRIES_W-1:0]        inv_index
);

    import tlb_pkg::*;

    localparam int VTAG_W = VPN_W - ENTRIES_W;

    // vpn is split into | vtag | set index |
    logic [ENTRIES_W-1:0] set_r;
    logic [ENTRIES_W-1:0] set_w;
    logic [VTAG_W-1:0]    vtag_req;
    logic [VTAG_W-1:0]    vtag_w;
    logic [VTAG_W-1:0]    vtag_rd;
    logic [VTAG_W-1:0]    vtag_cap;
    logic                 resolved;

    logic                 rd_en;
    logic                 wr_en;
    logic                 atag_wr_en;
    logic [ENTRIES_W-1:0] atag_wr_addr;
    logic [ATAG_W-1:0]    atag_wr_data;

    assign set_r    = vpn[ENTRIES_W-1:0];
    assign set_w    = vpn_w[ENTRIES_W-1:0];
    assign vtag_req = vpn[VPN_W-1:ENTRIES_W];
    assign vtag_w   = vpn_w[VPN_W-1:ENTRIES_W];

    assign rd_en = (cmd == TLB_CMD_RESOLVE);
    assign wr_en = (cmd == TLB_CMD_WRITE);

    // invalidate only touches the access tag, zeroing the valid bit
    assign atag_wr_en   = wr_en || (cmd == TLB_CMD_INVALIDATE);
    assign atag_wr_addr = wr_en ? set_w : inv_index;
    assign atag_wr_data = wr_en ? atag_w : '0;

    tlb_storage #(.ELEMENTS_W(ENTRIES_W), .WIDTH(PPN_W)) i_ptag (
        .clk        (clk),
        .read       (rd_en),
        .read_addr  (set_r),
        .read_data  (ppn_r),
        .write      (wr_en),
        .write_addr (set_w),
        .write_data (ppn_w)
    );

    tlb_storage #(.ELEMENTS_W(ENTRIES_W), .WIDTH(VTAG_W)) i_vtag (
        .clk        (clk),
        .read       (rd_en),
        .read_addr  (set_r),
        .read_data  (vtag_rd),
        .write      (wr_en),
        .write_addr (set_w),
        .write_data (vtag_w)
    );

    tlb_storage #(.ELEMENTS_W(ENTRIES_W), .WIDTH(ATAG_W)) i_atag (
        .clk        (clk),
        .read       (rd_en),
        .read_addr  (set_r),
        .read_data  (atag_r),
        .write      (atag_wr_en),
        .write_addr (atag_wr_addr),
        .write_data (atag_wr_data)
    );

    // request tag lines up with the registered storage output
    always_ff @(posedge clk) begin
        if (rd_en) begin
            vtag_cap <= vtag_req;
        end
    end

    // no hit before the first resolve has completed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resolved <= 1'b0;
        end else if (rd_en) begin
            resolved <= 1'b1;
        end
    end

    assign hit = resolved && atag_r[0] && (vtag_cap == vtag_rd);

endmodule

`default_nettype wire

// ==== tlb_storage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tlb_storage #(
    parameter int ELEMENTS_W = 4,
    parameter int WIDTH      = 8
) (
    input  wire logic                  clk,
    input  wire logic                  read,
    input  wire logic [ELEMENTS_W-1:0] read_addr,
    output      logic [WIDTH-1:0]      read_data,
    input  wire logic                  write,
    input  wire logic [ELEMENTS_W-1:0] write_addr,
    input  wire logic [WIDTH-1:0]      write_data
);

    logic [WIDTH-1:0] mem [2**ELEMENTS_W];

    // read-before-write on an address collision
    always_ff @(posedge clk) begin
        if (read) begin
            read_data <= mem[read_addr];
        end
        if (write) begin
            mem[write_addr] <= write_data;
        end
    end

endmodule

`default_nettype wire

// ==== tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

    // command encoding shared by the fsm, the array and the ways
    typedef enum logic [1:0] {
        TLB_CMD_NONE       = 2'd0,
        TLB_CMD_RESOLVE    = 2'd1,
        TLB_CMD_WRITE      = 2'd2,
        TLB_CMD_INVALIDATE = 2'd3
    } tlb_cmd_t;

    // flush sequencer states
    typedef enum logic [1:0] {
        FLUSH_IDLE  = 2'd0,
        FLUSH_SWEEP = 2'd1,
        FLUSH_DONE  = 2'd2
    } flush_state_t;

    // virtual page number, 32-bit address with 4 KiB pages
    localparam int VPN_W = 20;

    // physical page number
    localparam int PPN_W = 22;

    // access tag, bit 0 is the valid bit
    localparam int ATAG_W = 8;

endpackage

`default_nettype wire
